// ==== Bender.yml ====
package:
  name: panel_controller

sources:
  - files:
      - hw/panel_pkg.sv
      - hw/key_decode.sv
      - hw/menu_fsm.sv
      - hw/write_bank.sv
      - hw/master_command.sv
      - hw/panel_top.sv
  - target: test
    files:
      - dv/panel_assertions.sv
      - dv/tb_panel.sv

// ==== dv/panel_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module panel_assertions import panel_pkg::*; #(
    parameter int DATA_WIDTH = 16
) (
    input logic                                    clk,
    input logic                                    rstN,
    input main_state_t                             state,
    input logic [MASTER_COUNT-1:0]                 start,
    input logic [MASTER_COUNT-1:0]                 burst,
    input logic [MASTER_COUNT-1:0]                 done_com,
    input logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0] data_out,
    input logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0] readback,
    input status_leds_t                            leds
);

    int fail_count = 0;    // read by the testbench

    // held reset leaves the panel idle and every master quiet
    reset_quiet: assert property (@(posedge clk)
        (!rstN ##1 !rstN) |-> (start == '0 && burst == '0 && leds == 4'b1000))
        else begin
            $error("start, burst or leds wrong during reset");
            fail_count++;
        end

    start_in_state: assert property (@(posedge clk) disable iff (!rstN)
        |start |-> state inside {config_masters, communicating})
        else begin
            $error("start pulse outside configuration and communication");
            fail_count++;
        end

    // common start is one cycle wide and hits both masters at once
    comm_start_single: assert property (@(posedge clk) disable iff (!rstN)
        (state == communicating && start != '0) |-> start == '1 ##1 start == '0)
        else begin
            $error("communication start not a single cycle on both masters");
            fail_count++;
        end

    done_after_masters: assert property (@(posedge clk) disable iff (!rstN)
        (state == communicating ##1 leds.done) |-> $past(done_com) == '1)
        else begin
            $error("done reached before both masters reported done");
            fail_count++;
        end

    readback_lag: assert property (@(posedge clk) disable iff (!rstN)
        1'b1 |=> readback == $past(data_out))    // one register stage
        else begin
            $error("readback does not follow data_out by one cycle");
            fail_count++;
        end

endmodule

bind panel_top panel_assertions #(.DATA_WIDTH(DATA_WIDTH)) u_assertions (
    .clk, .rstN, .state, .start, .burst, .done_com, .data_out, .readback, .leds
);

`default_nettype wire

// ==== dv/tb_panel.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_panel import panel_pkg::*; ();

    localparam int DATA_WIDTH    = 16;
    localparam int BANK_DEPTH    = 16;
    localparam int SLAVE_DEPTH_1 = 4096;
    localparam int ADDR_WIDTH    = $clog2(SLAVE_DEPTH_1);
    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int STEP_KEY      = 1;
    localparam int ADDR_KEY      = 2;
    localparam int RUN_COUNT     = 3;
    localparam int RUN_CYCLES    = 300;    // longest menu run with slack
    localparam int WATCHDOG_NS   = RUN_COUNT * RUN_CYCLES * CLK_PERIOD * 11;  // about 40 us

    logic                                        clk;
    logic                                        rstN;
    logic [KEY_COUNT-1:0]                        key;
    logic [SW_WIDTH-1:0]                         sw;
    logic [MASTER_COUNT-1:0]                     done_com;
    logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]     data_out;
    logic [MASTER_COUNT-1:0]                     start;
    logic [MASTER_COUNT-1:0]                     burst;
    logic [MASTER_COUNT-1:0]                     rd_wr;
    logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0] slave_id;
    logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0]     address;
    logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]     data;
    logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]     readback;
    status_leds_t                                leds;

    logic [15:0]                                 stim_lfsr  = 16'd53483;
    logic [15:0]                                 model_lfsr = 16'd53483;
    logic [DATA_WIDTH-1:0]                       exp_words [MASTER_COUNT][BANK_DEPTH];
    int                                          exp_count [MASTER_COUNT];
    logic [ADDR_WIDTH-1:0]                       exp_addr  [MASTER_COUNT];
    logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0] exp_sid;
    logic [MASTER_COUNT-1:0]                     exp_rdwr;
    int                                          done_wait [MASTER_COUNT];
    int                                          start_cycles;   // start-high cycles since reset

    panel_top #(
        .DATA_WIDTH(DATA_WIDTH), .BANK_DEPTH(BANK_DEPTH), .SLAVE_DEPTH_1(SLAVE_DEPTH_1)
    ) UUT (
        .clk, .rstN, .key, .sw, .done_com, .data_out,
        .start, .burst, .rd_wr, .slave_id, .address, .data, .readback, .leds
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count,
                             output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = galois_step(state);
        end
    endtask

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0d ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic press_key(input int idx, input logic [SW_WIDTH-1:0] value);
        sw       = value;
        key[idx] = 1'b0;
        repeat (4) next_cycle();
        key[idx] = 1'b1;
        repeat (4) next_cycle();
    endtask

    task automatic apply_reset();
        rstN = 1'b0;
        repeat (4) next_cycle();
        rstN = 1'b1;
    endtask

    // each master gets max(words, 2) two-cycle slots with start on the first and last slot
    task automatic check_config_sequence();
        int                    n;
        int                    slots;
        logic [DATA_WIDTH-1:0] want;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            n     = exp_count[m];
            slots = (n < 2) ? 2 : n;
            while (!start[m]) next_cycle();
            check_value($sformatf("address[%0d]", m), exp_addr[m], address[m]);
            for (int s = 0; s < slots; s++) begin
                for (int c = 0; c < CONFIG_CYCLES; c++) begin
                    if (s != 0 || c != 0) next_cycle();
                    want = (s < n) ? exp_words[m][s] : '0;    // unwritten words read zero
                    check_value($sformatf("data[%0d]", m), want, data[m]);
                    check_value($sformatf("start[%0d]", m),
                                (c == 0) && (s == 0 || s == slots - 1), start[m]);
                    check_value($sformatf("burst[%0d]", m), n > 1, burst[m]);
                    check_value($sformatf("slave_id[%0d]", m), exp_sid[m], slave_id[m]);
                    check_value($sformatf("rd_wr[%0d]", m), exp_rdwr[m], rd_wr[m]);
                end
            end
        end
    endtask

    task automatic configure_and_run(input logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0] sid,
                                     input logic [MASTER_COUNT-1:0] rdwr,
                                     input int n1, input int n2);
        logic [31:0] bits;
        exp_sid      = sid;
        exp_rdwr     = rdwr;
        exp_count[0] = n1;
        exp_count[1] = n2;
        apply_reset();
        press_key(STEP_KEY, SW_WIDTH'(sid));
        press_key(STEP_KEY, SW_WIDTH'(rdwr));
        press_key(STEP_KEY, SW_WIDTH'({n2 > 0, n1 > 0}));
        for (int m = 0; m < MASTER_COUNT; m++) begin
            for (int i = 0; i < exp_count[m]; i++) begin
                draw_bits(stim_lfsr, DATA_WIDTH, bits);
                exp_words[m][i] = bits[DATA_WIDTH-1:0];
                // the last word goes in with step
                press_key((i == exp_count[m] - 1) ? STEP_KEY : ADDR_KEY,
                          SW_WIDTH'(exp_words[m][i]));
            end
        end
        draw_bits(stim_lfsr, ADDR_WIDTH, bits);
        exp_addr[0] = bits[ADDR_WIDTH-1:0];
        press_key(STEP_KEY, SW_WIDTH'(exp_addr[0]));
        draw_bits(stim_lfsr, ADDR_WIDTH, bits);
        exp_addr[1] = bits[ADDR_WIDTH-1:0];
        fork
            press_key(STEP_KEY, SW_WIDTH'(exp_addr[1]));
            check_config_sequence();
        join
        while (!leds.ready) next_cycle();
        check_value("leds", 4'b0100, leds);
        check_value("address", 0, address);
        fork
            press_key(STEP_KEY, sw);
            begin
                while (start != '1) next_cycle();
                check_value("leds", 4'b0010, leds);    // common start falls in communicating
            end
        join
        while (!leds.done) next_cycle();
        check_value("done_com", 2'b11, done_com);
        check_value("leds", 4'b0001, leds);
        draw_bits(stim_lfsr, ADDR_WIDTH, bits);
        press_key(ADDR_KEY, SW_WIDTH'(bits[ADDR_WIDTH-1:0]));
        for (int m = 0; m < MASTER_COUNT; m++) begin
            check_value($sformatf("address[%0d]", m), bits[ADDR_WIDTH-1:0], address[m]);
        end
    endtask

    // master model returns fresh read data each cycle and raises done after the common start
    always @(posedge clk) begin : master_model
        logic [31:0] bits;
        #DRIVE_DELAY;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            draw_bits(model_lfsr, DATA_WIDTH, bits);
            data_out[m] = bits[DATA_WIDTH-1:0];
            if (!rstN) begin
                done_com[m]  = 1'b0;
                done_wait[m] = 0;
            end else if (start == '1) begin
                draw_bits(model_lfsr, 4, bits);
                done_wait[m] = 2 + int'(bits[3:0]);
            end else if (done_wait[m] > 0) begin
                done_wait[m]--;
                done_com[m] = (done_wait[m] == 0);    // stays high until reset
            end
        end
        if (!rstN) start_cycles = 0;
        else if (|start) start_cycles++;
    end

    always @(UUT.u_assertions.fail_count) begin
        if (UUT.u_assertions.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            end_with_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all menu runs finished");
        end_with_failure();
    end

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        key      = '1;
        sw       = '0;
        done_com = '0;
        data_out = '0;
        // no slave on either master goes straight to done
        apply_reset();
        check_value("leds", 4'b1000, leds);
        check_value("start", 0, start);
        press_key(STEP_KEY, '0);
        while (!leds.done) next_cycle();
        check_value("start_cycles", 0, start_cycles);
        configure_and_run({2'd3, 2'd1}, 2'b01, 3, 1);
        configure_and_run({2'd1, 2'd2}, 2'b10, 0, 0);    // no bank words so data stays zero
        if (UUT.u_assertions.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("bound assertions on the DUT reported errors");
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== hw/key_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_decode import panel_pkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [KEY_COUNT-1:0] key,       // active low, assumed bounce free
    output key_events_t          events
);

    // bit 0 follows key 1 (step), bit 1 follows key 2 (next address)
    logic [1:0] sync_1;
    logic [1:0] sync_2;
    logic [1:0] prev;
    logic [1:0] fall;

    assign fall = prev & ~sync_2;   // released last cycle, pressed now

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sync_1 <= '1;               // released keys read high
            sync_2 <= '1;
            prev   <= '1;
            events <= '0;
        end else begin
            sync_1           <= key[2:1];
            sync_2           <= sync_1;
            prev             <= sync_2;
            events.step      <= fall[0];
            events.next_addr <= fall[1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/master_command.sv ====
`timescale 1ns/10ps
`default_nettype none

module master_command import panel_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 12,
    parameter int BANK_DEPTH = 16
) (
    input  logic                                            clk,
    input  logic                                            rstN,
    input  main_state_t                                     state,
    input  master_setup_t                                   setup,
    input  logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0]         start_addr,
    input  key_events_t                                     events,
    input  logic [SW_WIDTH-1:0]                             sw,
    input  logic [MASTER_COUNT-1:0][$clog2(BANK_DEPTH):0]   word_count,
    input  logic [DATA_WIDTH-1:0]                           bank_data,
    input  logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]         data_out,
    output logic [$clog2(MASTER_COUNT)-1:0]                 bank_rd_master,
    output logic [$clog2(BANK_DEPTH)-1:0]                   bank_rd_addr,
    output logic                                            config_finished,
    output logic [MASTER_COUNT-1:0]                         start,
    output logic [MASTER_COUNT-1:0]                         burst,
    output logic [MASTER_COUNT-1:0]                         rd_wr,
    output logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0]     slave_id,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0]         address,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]         data,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]         readback
);

    localparam int BW  = $clog2(BANK_DEPTH);
    localparam int CW  = BW + 1;
    localparam int MW  = $clog2(MASTER_COUNT);
    localparam int CYW = $clog2(CONFIG_CYCLES);

    config_state_t                  cfg_state;
    logic [CYW-1:0]                 cyc;
    logic [MW-1:0]                  cur_m;
    logic [MW-1:0]                  nxt_m;
    logic [BW-1:0]                  k;          // bank word in the current slot
    logic [CW-1:0]                  k_nxt;
    logic [MASTER_COUNT-1:0][CW-1:0] n_words;
    logic                           launch;
    logic                           slot_end;
    logic [DATA_WIDTH-1:0]          fetched;

    assign rd_wr    = setup.rd_wr;
    assign slave_id = setup.slave_id;

    always_comb begin
        for (int m = 0; m < MASTER_COUNT; m++) begin
            n_words[m] = setup.ext_write[m] ? word_count[m] : '0;
        end
    end

    assign nxt_m    = cur_m + 1'b1;
    assign k_nxt    = CW'(k) + 1'b1;
    assign launch   = (state == start_addr_m2) && events.step;
    assign slot_end = (cfg_state != config_done) && (cyc == CYW'(CONFIG_CYCLES - 1));

    // bank address of the word for the slot that follows
    always_comb begin
        case (cfg_state)
            config_done: bank_rd_master = '0;       // first word of master 1 at launch
            config_last: bank_rd_master = nxt_m;
            default:     bank_rd_master = cur_m;
        endcase
        bank_rd_addr = (cfg_state inside {config_start, config_middle}) ? k_nxt[BW-1:0] : '0;
    end

    // words past the written count go out as zero
    assign fetched = (CW'(bank_rd_addr) < n_words[bank_rd_master]) ? bank_data : '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state       <= config_done;
            cyc             <= '0;
            cur_m           <= '0;
            k               <= '0;
            config_finished <= 1'b0;
            start           <= '0;
            burst           <= '0;
            address         <= '0;
            data            <= '0;
        end else begin
            start           <= '0;
            config_finished <= 1'b0;
            if (launch) begin
                cfg_state  <= config_start;
                cyc        <= '0;
                cur_m      <= '0;
                k          <= '0;
                start[0]   <= 1'b1;
                address[0] <= start_addr[0];
                data[0]    <= fetched;
                for (int m = 0; m < MASTER_COUNT; m++) begin
                    burst[m] <= (n_words[m] > CW'(1));
                end
            end else if (cfg_state != config_done) begin
                cyc <= cyc + 1'b1;
                if (slot_end) begin
                    cyc <= '0;
                    if (cfg_state == config_last) begin
                        if (cur_m == MW'(MASTER_COUNT - 1)) begin
                            cfg_state       <= config_done;
                            config_finished <= 1'b1;
                            address         <= '0;
                        end else begin
                            cfg_state      <= config_start;     // move on to the next master
                            cur_m          <= nxt_m;
                            k              <= '0;
                            start[nxt_m]   <= 1'b1;
                            address[nxt_m] <= start_addr[nxt_m];
                            data[nxt_m]    <= fetched;
                        end
                    end else begin
                        k            <= k_nxt[BW-1:0];
                        data[cur_m]  <= fetched;
                        if (k_nxt + 1'b1 >= n_words[cur_m]) begin
                            cfg_state    <= config_last;
                            start[cur_m] <= 1'b1;           // marks the final word
                        end else begin
                            cfg_state <= config_middle;
                        end
                    end
                end
            end else if ((state == communication_ready) && events.step) begin
                start <= '1;                                // both masters together
            end else if ((state == communication_done) && events.next_addr) begin
                address <= {MASTER_COUNT{sw[ADDR_WIDTH-1:0]}};
            end
        end
    end

    always_ff @(posedge clk) begin
        readback <= data_out;
    end

endmodule

`default_nettype wire

// ==== hw/menu_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module menu_fsm import panel_pkg::*; #(
    parameter int ADDR_WIDTH = 12,
    parameter int BANK_DEPTH = 16
) (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  key_events_t                             events,
    input  logic [SW_WIDTH-1:0]                     sw,
    input  logic                                    config_finished,
    input  logic [MASTER_COUNT-1:0]                 done_com,
    output main_state_t                             state,
    output master_setup_t                           setup,
    output logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0] start_addr,
    output logic                                    bank_we,
    output logic [$clog2(MASTER_COUNT)-1:0]         bank_master,
    output logic [$clog2(BANK_DEPTH)-1:0]           bank_addr,
    output status_leds_t                            leds
);

    main_state_t next_state;
    logic        ext_state;

    assign ext_state = state inside {external_write_m1, external_write_m1_2, external_write_m2};

    // step stores the word on the switches as well as leaving the state
    assign bank_we     = ext_state && (events.step || events.next_addr);
    assign bank_master = $clog2(MASTER_COUNT)'(state == external_write_m2);

    always_comb begin
        next_state = state;
        case (state)
            master_slave_sel: if (events.step) begin
                // nothing to talk to when both masters have no slave
                if (sw[MASTER_COUNT*SLAVE_ID_WIDTH-1:0] == '0) next_state = communication_done;
                else next_state = read_write_sel;
            end
            read_write_sel:      if (events.step) next_state = external_write_sel;
            external_write_sel: if (events.step) begin
                case (sw[1:0])
                    2'b01:   next_state = external_write_m1;
                    2'b10:   next_state = external_write_m2;
                    2'b11:   next_state = external_write_m1_2;
                    default: next_state = start_addr_m1;
                endcase
            end
            external_write_m1:   if (events.step) next_state = start_addr_m1;
            external_write_m1_2: if (events.step) next_state = external_write_m2;
            external_write_m2:   if (events.step) next_state = start_addr_m1;
            start_addr_m1:       if (events.step) next_state = start_addr_m2;
            start_addr_m2:       if (events.step) next_state = config_masters;
            config_masters:      if (config_finished) next_state = communication_ready;
            communication_ready: if (events.step) next_state = communicating;
            communicating:       if (&done_com) next_state = communication_done;
            default:             next_state = state;    // done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= master_slave_sel;
            setup      <= '0;
            start_addr <= '0;
            bank_addr  <= '0;
        end else begin
            state <= next_state;

            // switch selections are taken on the step that confirms them
            if (events.step) begin
                case (state)
                    master_slave_sel:   setup.slave_id  <= sw[MASTER_COUNT*SLAVE_ID_WIDTH-1:0];
                    read_write_sel:     setup.rd_wr     <= sw[MASTER_COUNT-1:0];
                    external_write_sel: setup.ext_write <= sw[MASTER_COUNT-1:0];
                    start_addr_m1:      start_addr[0]   <= sw[ADDR_WIDTH-1:0];
                    start_addr_m2:      start_addr[1]   <= sw[ADDR_WIDTH-1:0];
                    default: ;
                endcase
            end

            if (ext_state) begin
                if (events.step) bank_addr <= '0;   // next master starts at word 0
                else if (events.next_addr) bank_addr <= bank_addr + 1'b1;
            end
        end
    end

    assign leds.idle          = (state == master_slave_sel);
    assign leds.ready         = (state == communication_ready);
    assign leds.communicating = (state == communicating);
    assign leds.done          = (state == communication_done);

endmodule

`default_nettype wire

// ==== hw/panel_pkg.sv ====
`default_nettype none

package panel_pkg;

    localparam int MASTER_COUNT   = 2;
    localparam int SLAVE_ID_WIDTH = 2;    // id zero selects no slave
    localparam int SW_WIDTH       = 18;
    localparam int KEY_COUNT      = 4;
    localparam int CONFIG_CYCLES  = 2;    // clock cycles spent in each config sub-state

    // operator menu, one select state per master where needed
    typedef enum logic [3:0] {
        master_slave_sel,
        read_write_sel,
        external_write_sel,
        external_write_m1,
        external_write_m1_2,
        external_write_m2,
        start_addr_m1,
        start_addr_m2,
        config_masters,
        communication_ready,
        communicating,
        communication_done
    } main_state_t;

    typedef enum logic [1:0] {
        config_start,
        config_middle,
        config_last,
        config_done     // also the idle state between sequences
    } config_state_t;

    // key 0 is the reset, key 3 is unused
    typedef struct packed {
        logic step;         // key 1
        logic next_addr;    // key 2
    } key_events_t;

    typedef struct packed {
        logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0] slave_id;
        logic [MASTER_COUNT-1:0]                     rd_wr;      // 1 is write
        logic [MASTER_COUNT-1:0]                     ext_write;  // words come from the bank
    } master_setup_t;

    typedef struct packed {
        logic idle;
        logic ready;
        logic communicating;
        logic done;
    } status_leds_t;

endpackage

`default_nettype wire

// ==== hw/panel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module panel_top import panel_pkg::*; #(
    parameter int DATA_WIDTH    = 16,
    parameter int BANK_DEPTH    = 16,
    parameter int SLAVE_DEPTH_1 = 4096,
    parameter int SLAVE_DEPTH_2 = 4096,
    parameter int SLAVE_DEPTH_3 = 2048
) (
    input  logic                                                   clk,
    input  logic                                                   rstN,
    input  logic [KEY_COUNT-1:0]                                   key,
    input  logic [SW_WIDTH-1:0]                                    sw,
    input  logic [MASTER_COUNT-1:0]                                done_com,
    input  logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]                data_out,
    output logic [MASTER_COUNT-1:0]                                start,
    output logic [MASTER_COUNT-1:0]                                burst,
    output logic [MASTER_COUNT-1:0]                                rd_wr,
    output logic [MASTER_COUNT-1:0][SLAVE_ID_WIDTH-1:0]            slave_id,
    output logic [MASTER_COUNT-1:0][$clog2(SLAVE_DEPTH_1)-1:0]     address,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]                data,
    output logic [MASTER_COUNT-1:0][DATA_WIDTH-1:0]                readback,
    output status_leds_t                                           leds
);

    // slave 1 is the largest, so its width reaches every slave
    localparam int ADDR_WIDTH = $clog2(SLAVE_DEPTH_1);

    if (SLAVE_DEPTH_2 > SLAVE_DEPTH_1 || SLAVE_DEPTH_3 > SLAVE_DEPTH_1) begin : g_depth_check
        $error("slave 1 must be the deepest slave");
    end
    if (DATA_WIDTH < 4 || DATA_WIDTH > 16) begin : g_width_check
        $error("DATA_WIDTH must lie between 4 and 16");
    end

    key_events_t                                     events;
    main_state_t                                     state;
    master_setup_t                                   setup;
    logic [MASTER_COUNT-1:0][ADDR_WIDTH-1:0]         start_addr;
    logic                                            bank_we;
    logic [$clog2(MASTER_COUNT)-1:0]                 bank_master;
    logic [$clog2(BANK_DEPTH)-1:0]                   bank_addr;
    logic [MASTER_COUNT-1:0][$clog2(BANK_DEPTH):0]   word_count;
    logic [$clog2(MASTER_COUNT)-1:0]                 bank_rd_master;
    logic [$clog2(BANK_DEPTH)-1:0]                   bank_rd_addr;
    logic [DATA_WIDTH-1:0]                           bank_data;
    logic                                            config_finished;

    key_decode u_key_decode (.clk, .rstN, .key, .events);

    menu_fsm #(.ADDR_WIDTH(ADDR_WIDTH), .BANK_DEPTH(BANK_DEPTH)) u_menu_fsm (
        .clk, .rstN, .events, .sw, .config_finished, .done_com,
        .state, .setup, .start_addr, .bank_we, .bank_master, .bank_addr, .leds
    );

    write_bank #(.DATA_WIDTH(DATA_WIDTH), .BANK_DEPTH(BANK_DEPTH)) u_write_bank (
        .clk, .rstN,
        .we        (bank_we),
        .wr_master (bank_master),
        .wr_addr   (bank_addr),
        .wr_data   (sw[DATA_WIDTH-1:0]),
        .rd_master (bank_rd_master),
        .rd_addr   (bank_rd_addr),
        .rd_data   (bank_data),
        .word_count
    );

    master_command #(
        .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .BANK_DEPTH(BANK_DEPTH)
    ) u_master_command (
        .clk, .rstN, .state, .setup, .start_addr, .events, .sw, .word_count, .bank_data,
        .data_out, .bank_rd_master, .bank_rd_addr, .config_finished,
        .start, .burst, .rd_wr, .slave_id, .address, .data, .readback
    );

endmodule

`default_nettype wire

// ==== hw/write_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_bank import panel_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int BANK_DEPTH = 16
) (
    input  logic                                                 clk,
    input  logic                                                 rstN,
    input  logic                                                 we,
    input  logic [$clog2(MASTER_COUNT)-1:0]                      wr_master,
    input  logic [$clog2(BANK_DEPTH)-1:0]                        wr_addr,
    input  logic [DATA_WIDTH-1:0]                                wr_data,
    input  logic [$clog2(MASTER_COUNT)-1:0]                      rd_master,
    input  logic [$clog2(BANK_DEPTH)-1:0]                        rd_addr,
    output logic [DATA_WIDTH-1:0]                                rd_data,
    output logic [MASTER_COUNT-1:0][$clog2(BANK_DEPTH):0]        word_count
);

    logic [DATA_WIDTH-1:0] mem [MASTER_COUNT][BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we) mem[wr_master][wr_addr] <= wr_data;
    end

    assign rd_data = mem[rd_master][rd_addr];   // asynchronous read

    // one count per master, stops at a full bank
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            word_count <= '0;
        end else if (we && (word_count[wr_master] < BANK_DEPTH)) begin
            word_count[wr_master] <= word_count[wr_master] + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/panel_pkg.sv
hw/key_decode.sv
hw/menu_fsm.sv
hw/write_bank.sv
hw/master_command.sv
hw/panel_top.sv
dv/panel_assertions.sv
dv/tb_panel.sv
